//--- tb.f
hw/dcache_pkg.sv
hw/dcache_tag_lookup.sv
hw/dcache_data_array.sv
hw/dcache_miss_ctrl.sv
hw/dcache_top.sv
sim/tb_clk_gen.sv
sim/tb_dcache.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_dcache
FILELIST  = tb.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	! grep -q "TEST FAIL" $(LOG)
	grep -q "TEST PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- sim/tb_dcache.sv
`timescale 1ns/1ns
`default_nettype none

module tb_dcache
	import dcache_pkg::*;
;
	logic clk, rst_n;
	logic cpu_re, cpu_we, cpu_stall, cpu_rdata_valid;
	addr_t cpu_addr, araddr, awaddr;
	be_t cpu_be;
	word_t cpu_wdata, cpu_rdata, rdata, wdata;
	logic arvalid, arready, rvalid, rlast, rready;
	logic awvalid, awready, wvalid, wlast, wready, bvalid;

	// roughly 160 misses at up to 70 cycles each leave ample margin
	localparam int CYCLE_LIMIT = 20000;

	word_t mem [addr_t];
	word_t img [addr_t];
	logic mv [2][64];
	logic md [2][64];
	logic [19:0] mt [2][64];
	logic ml [64];
	logic [31:0] lcg_state = 32'h31e8_748e;
	int cycles = 0;
	word_t exp_rdata;
	logic exp_ar, exp_aw;
	addr_t exp_ar_addr, exp_aw_addr;
	int ar_cnt, aw_cnt;

	tb_clk_gen u_clk_gen (.clk(clk), .rst_n(rst_n));

	dcache_top u_dcache_top (.*);

	function automatic logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// initial memory contents depend on every address bit
	function automatic word_t fill_word(addr_t a);
		return a ^ {a[15:0], a[31:16]} ^ 32'h6b2d_91c4;
	endfunction

	function automatic word_t mem_word(addr_t a);
		if (mem.exists(a))
			return mem[a];
		return fill_word(a);
	endfunction

	function automatic word_t img_word(addr_t a);
		if (img.exists(a))
			return img[a];
		return fill_word(a);
	endfunction

	function automatic addr_t make_addr(logic [19:0] tg, logic [5:0] idx, logic [3:0] off);
		return {tg, idx, off, 2'b00};
	endfunction

	// expected word plus predicted refill and write-back of one access
	function automatic word_t ref_access(input addr_t a, input logic we, input be_t be,
		input word_t wd, output logic ar_exp, output logic aw_exp, output addr_t aw_line);
		int idx;
		int w;
		logic [19:0] tg;
		addr_t key;
		word_t cur;
		idx = a[11:6];
		tg = a[31:12];
		key = {a[31:2], 2'b00};
		ar_exp = 1'b0;
		aw_exp = 1'b0;
		aw_line = '0;
		if (mv[0][idx] && mt[0][idx] == tg)
			w = 0;
		else if (mv[1][idx] && mt[1][idx] == tg)
			w = 1;
		else
		begin
			ar_exp = 1'b1;
			if (!mv[0][idx])
				w = 0;
			else if (!mv[1][idx])
				w = 1;
			else
				w = ml[idx];
			if (mv[w][idx] && md[w][idx])
			begin
				aw_exp = 1'b1;
				aw_line = {mt[w][idx], a[11:6], 6'b0};
			end
			mv[w][idx] = 1'b1;
			mt[w][idx] = tg;
			md[w][idx] = 1'b0;
		end
		ml[idx] = (w == 0);
		cur = img_word(key);
		if (we)
		begin
			md[w][idx] = 1'b1;
			for (int b = 0; b < 4; b++)
				if (be[b])
					cur[8*b +: 8] = wd[8*b +: 8];
			img[key] = cur;
		end
		return cur;
	endfunction

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("TEST FAIL");
		$fatal(1);
	endtask

	task automatic check_word(input string name, input word_t got, input word_t exp);
		if (got !== exp)
			fail_run($sformatf("FAILED %s got %h expected %h", name, got, exp));
	endtask

	task automatic check_addr(input string name, input addr_t got, input addr_t exp);
		if (got !== exp)
			fail_run($sformatf("FAILED %s got %h expected %h", name, got, exp));
	endtask

	always @(posedge clk)
	begin
		cycles++;
		if (cycles >= CYCLE_LIMIT)
			fail_run("timeout, the cache did not finish the tests in time");
	end

	// read results are stable at the falling edge
	always @(negedge clk)
	begin
		if (rst_n && cpu_rdata_valid)
			check_word("cpu_rdata", cpu_rdata, exp_rdata);
	end

	// memory model sampling transfers at the falling edge and driving 1 ns after the rise
	initial
	begin
		logic ar_x, r_x, aw_x, w_x, rd_active;
		addr_t rd_base, wr_base;
		int rd_beat, wr_beat;
		logic [31:0] r;
		arready = 1'b0;
		rvalid = 1'b0;
		rlast = 1'b0;
		rdata = '0;
		awready = 1'b0;
		wready = 1'b0;
		bvalid = 1'b0;
		rd_active = 1'b0;
		rd_beat = 0;
		wr_beat = 0;
		rd_base = '0;
		wr_base = '0;
		forever
		begin
			@(negedge clk);
			ar_x = arvalid && arready;
			r_x = rvalid && rready;
			aw_x = awvalid && awready;
			w_x = wvalid && wready;
			if (rst_n && (rready !== rd_active))
				fail_run("rready is not high exactly while the refill burst runs");
			r = next_rand();
			if (ar_x)
			begin
				if (!exp_ar)
					fail_run("read burst issued on an access that should hit");
				check_addr("araddr", araddr, exp_ar_addr);
				ar_cnt++;
				rd_base = araddr;
			end
			if (aw_x)
			begin
				if (!exp_aw)
					fail_run("write-back burst issued without a dirty victim");
				check_addr("awaddr", awaddr, exp_aw_addr);
				aw_cnt++;
				wr_base = awaddr;
				wr_beat = 0;
			end
			if (w_x)
			begin
				check_word("wdata", wdata, img_word(wr_base + 4 * wr_beat));
				if (wlast !== (wr_beat == 15))
					fail_run("wlast does not mark the sixteenth write beat");
				mem[wr_base + 4 * wr_beat] = wdata;
				wr_beat++;
			end
			@(posedge clk);
			#1;
			bvalid = w_x && (wr_beat == 16);
			if (ar_x)
			begin
				rd_active = 1'b1;
				rd_beat = 0;
			end
			if (r_x)
			begin
				rd_beat++;
				if (rd_beat == 16)
					rd_active = 1'b0;
			end
			if (!rd_active)
				rvalid = 1'b0;
			else if (r_x || !rvalid)
				rvalid = r[24] | r[25];
			rdata = mem_word(rd_base + 4 * rd_beat);
			rlast = rd_active && (rd_beat == 15);
			arready = r[20] | r[21];
			awready = r[22] | r[23];
			wready = r[26] | r[27];
		end
	end

	task automatic cpu_access(input addr_t a, input logic we, input be_t be, input word_t wd);
		logic ar_e, aw_e;
		addr_t awl;
		exp_rdata = ref_access(a, we, be, wd, ar_e, aw_e, awl);
		exp_ar = ar_e;
		exp_aw = aw_e;
		exp_ar_addr = {a[31:6], 6'b0};
		exp_aw_addr = awl;
		ar_cnt = 0;
		aw_cnt = 0;
		cpu_addr = a;
		cpu_we = we;
		cpu_re = !we;
		cpu_be = be;
		cpu_wdata = wd;
		@(negedge clk);
		while (cpu_stall)
			@(negedge clk);
		@(posedge clk);
		#1;
		cpu_re = 1'b0;
		cpu_we = 1'b0;
		@(negedge clk);
		if (cpu_rdata_valid !== !we)
			fail_run("cpu_rdata_valid wrong in the cycle after the request was accepted");
		if (cpu_stall !== 1'b1)
			fail_run("cpu_stall low in the cycle after the request was accepted");
		if (ar_cnt != int'(ar_e))
			fail_run("number of read bursts differs from the predicted hit or miss");
		if (aw_cnt != int'(aw_e))
			fail_run("number of write-back bursts differs from the predicted victim");
		@(posedge clk);
		#1;
	endtask

	initial
	begin
		logic [31:0] r;
		cpu_re = 1'b0;
		cpu_we = 1'b0;
		cpu_addr = '0;
		cpu_be = '0;
		cpu_wdata = '0;
		exp_ar = 1'b0;
		exp_aw = 1'b0;
		for (int s = 0; s < 64; s++)
		begin
			mv[0][s] = 1'b0;
			mv[1][s] = 1'b0;
			md[0][s] = 1'b0;
			md[1][s] = 1'b0;
			ml[s] = 1'b0;
		end
		@(posedge rst_n);
		@(posedge clk);
		#1;
		// cold miss then same-line hit
		cpu_access(make_addr(20'h00100, 6'd5, 4'd3), 1'b0, 4'h0, '0);
		cpu_access(make_addr(20'h00100, 6'd5, 4'd7), 1'b0, 4'h0, '0);
		// byte merge on a hit line
		cpu_access(make_addr(20'h00100, 6'd5, 4'd3), 1'b1, 4'b0101, 32'h1122_3344);
		cpu_access(make_addr(20'h00100, 6'd5, 4'd3), 1'b1, 4'b1000, 32'hab00_0000);
		cpu_access(make_addr(20'h00100, 6'd5, 4'd3), 1'b0, 4'h0, '0);
		// third tag on index 5 pushes out the dirty line
		cpu_access(make_addr(20'h00200, 6'd5, 4'd0), 1'b0, 4'h0, '0);
		cpu_access(make_addr(20'h00300, 6'd5, 4'd9), 1'b0, 4'h0, '0);
		// lru order A, B, A, C leaves A resident
		cpu_access(make_addr(20'h00a00, 6'd9, 4'd1), 1'b0, 4'h0, '0);
		cpu_access(make_addr(20'h00b00, 6'd9, 4'd1), 1'b0, 4'h0, '0);
		cpu_access(make_addr(20'h00a00, 6'd9, 4'd2), 1'b0, 4'h0, '0);
		cpu_access(make_addr(20'h00c00, 6'd9, 4'd1), 1'b0, 4'h0, '0);
		cpu_access(make_addr(20'h00a00, 6'd9, 4'd4), 1'b0, 4'h0, '0);
		cpu_access(make_addr(20'h00b00, 6'd9, 4'd4), 1'b0, 4'h0, '0);
		// random mix over two sets and four tags
		for (int i = 0; i < 300; i++)
		begin
			r = next_rand();
			cpu_access(make_addr({18'h0, r[9:8]} + 20'h1, 6'd2 + r[10], r[14:11]),
				r[16], (r[20:17] == 4'h0) ? 4'hf : r[20:17], next_rand());
		end
		$display("TEST PASS");
		$finish;
	end

endmodule

`default_nettype wire

//--- sim/tb_clk_gen.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clk_gen (
	output logic clk,
	output logic rst_n
);
	// 8 ns period
	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// reset held low over the first two rising edges
	initial
	begin
		rst_n = 1'b0;
		repeat (2) @(posedge clk);
		#1 rst_n = 1'b1;
	end

endmodule

`default_nettype wire

//--- hw/dcache_top.sv
`timescale 1ns/1ns
`default_nettype none

module dcache_top
	import dcache_pkg::*;
(
	input  logic  clk,
	input  logic  rst_n,
	input  logic  cpu_re,
	input  logic  cpu_we,
	input  addr_t cpu_addr,
	input  be_t   cpu_be,
	input  word_t cpu_wdata,
	output logic  cpu_stall,
	output word_t cpu_rdata,
	output logic  cpu_rdata_valid,
	output addr_t araddr,
	output logic  arvalid,
	input  logic  arready,
	input  word_t rdata,
	input  logic  rvalid,
	input  logic  rlast,
	output logic  rready,
	output addr_t awaddr,
	output logic  awvalid,
	input  logic  awready,
	output word_t wdata,
	output logic  wvalid,
	output logic  wlast,
	input  logic  wready,
	input  logic  bvalid
);
	// lookup results and tag updates
	tag_t    lookup_tag;
	index_t  lookup_index;
	logic    hit;
	way_t    hit_way;
	way_t    victim_way;
	tag_t    victim_tag;
	logic    victim_dirty;
	logic    fill_en;
	tag_t    fill_tag;
	way_t    fill_way;
	logic    dirty_set;
	logic    dirty_clear;
	logic    touch;
	way_t    touch_way;

	// data array ports
	way_t    rd_way;
	index_t  rd_index;
	offset_t rd_offset;
	logic    wr_en;
	way_t    wr_way;
	index_t  wr_index;
	offset_t wr_offset;
	be_t     wr_be;
	word_t   wr_data;

	dcache_tag_lookup u_tag_lookup (.*);

	// the registered array word serves both the cpu and the write-back
	dcache_data_array u_data_array (
		.rd_data (cpu_rdata),
		.*
	);

	dcache_miss_ctrl u_miss_ctrl (
		.rd_data (cpu_rdata),
		.*
	);

endmodule

`default_nettype wire

//--- hw/dcache_miss_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module dcache_miss_ctrl
	import dcache_pkg::*;
(
	input  logic    clk,
	input  logic    rst_n,
	input  logic    cpu_re,
	input  logic    cpu_we,
	input  addr_t   cpu_addr,
	input  be_t     cpu_be,
	input  word_t   cpu_wdata,
	output logic    cpu_stall,
	output logic    cpu_rdata_valid,
	input  logic    hit,
	input  way_t    hit_way,
	input  way_t    victim_way,
	input  tag_t    victim_tag,
	input  logic    victim_dirty,
	output tag_t    lookup_tag,
	output index_t  lookup_index,
	output logic    fill_en,
	output tag_t    fill_tag,
	output way_t    fill_way,
	output logic    dirty_set,
	output logic    dirty_clear,
	output logic    touch,
	output way_t    touch_way,
	output way_t    rd_way,
	output index_t  rd_index,
	output offset_t rd_offset,
	input  word_t   rd_data,
	output logic    wr_en,
	output way_t    wr_way,
	output index_t  wr_index,
	output offset_t wr_offset,
	output be_t     wr_be,
	output word_t   wr_data,
	output addr_t   araddr,
	output logic    arvalid,
	input  logic    arready,
	input  word_t   rdata,
	input  logic    rvalid,
	input  logic    rlast,
	output logic    rready,
	output addr_t   awaddr,
	output logic    awvalid,
	input  logic    awready,
	output word_t   wdata,
	output logic    wvalid,
	output logic    wlast,
	input  logic    wready,
	input  logic    bvalid
);
	ctrl_state_t state;
	offset_t     beat;
	addr_t       req_addr;
	logic        req_we;
	be_t         req_be;
	word_t       req_wdata;
	way_t        vict_way;
	tag_t        vict_tag;
	logic        cpu_req;
	logic        beat_last;
	logic        w_xfer;
	logic        r_xfer;

	assign cpu_req   = cpu_re | cpu_we;
	assign beat_last = (beat == offset_t'(LINE_WORDS - 1));
	assign w_xfer    = wvalid & wready;
	assign r_xfer    = rvalid & rready;

	assign cpu_stall       = !(state == ST_IDLE && (hit || !cpu_req));
	assign cpu_rdata_valid = (state == ST_HIT) && !req_we;

	// idle looks up the live request, every other state the captured one
	assign lookup_tag   = (state == ST_IDLE) ? addr_tag(cpu_addr) : addr_tag(req_addr);
	assign lookup_index = (state == ST_IDLE) ? addr_index(cpu_addr) : addr_index(req_addr);

	assign touch       = (state == ST_HIT);
	assign touch_way   = hit_way;
	assign dirty_set   = (state == ST_HIT) && req_we;
	assign dirty_clear = (state == ST_WB_RESP) && bvalid;
	assign fill_en     = (state == ST_RF_DATA) && r_xfer && rlast;
	assign fill_tag    = addr_tag(req_addr);
	assign fill_way    = vict_way;

	// hit reads in idle, victim beats during write-back
	assign rd_way    = (state == ST_IDLE) ? hit_way : vict_way;
	assign rd_index  = lookup_index;
	assign rd_offset = (state == ST_IDLE) ? addr_offset(cpu_addr) : beat;

	always_comb
	begin
		wr_en     = 1'b0;
		wr_way    = vict_way;
		wr_index  = addr_index(req_addr);
		wr_offset = beat;
		wr_be     = '1;
		wr_data   = rdata;
		if (state == ST_HIT)
		begin
			wr_en     = req_we;
			wr_way    = hit_way;
			wr_offset = addr_offset(req_addr);
			wr_be     = req_be;
			wr_data   = req_wdata;
		end
		else if (state == ST_RF_DATA)
			wr_en = r_xfer;
	end

	assign araddr = line_addr(addr_tag(req_addr), addr_index(req_addr));
	assign awaddr = line_addr(vict_tag, addr_index(req_addr));
	// held while the read address is held
	assign wdata  = rd_data;

	always_ff @(posedge clk)
	begin
		if (state == ST_IDLE)
		begin
			req_addr  <= cpu_addr;
			req_we    <= cpu_we;
			req_be    <= cpu_be;
			req_wdata <= cpu_wdata;
			vict_way  <= victim_way;
			vict_tag  <= victim_tag;
		end
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			state   <= ST_IDLE;
			beat    <= '0;
			arvalid <= 1'b0;
			rready  <= 1'b0;
			awvalid <= 1'b0;
			wvalid  <= 1'b0;
			wlast   <= 1'b0;
		end
		else
		begin
			case (state)
				ST_IDLE:
				begin
					beat <= '0;
					if (cpu_req && hit)
						state <= ST_HIT;
					else if (cpu_req && victim_dirty)
					begin
						state   <= ST_WB_ADDR;
						awvalid <= 1'b1;
					end
					else if (cpu_req)
					begin
						state   <= ST_RF_ADDR;
						arvalid <= 1'b1;
					end
				end
				ST_HIT:
					state <= ST_IDLE;
				ST_WB_ADDR:
				begin
					// beat 0 was read while aw waited
					if (awready)
					begin
						awvalid <= 1'b0;
						wvalid  <= 1'b1;
						state   <= ST_WB_DATA;
					end
				end
				ST_WB_DATA:
				begin
					if (w_xfer)
					begin
						wvalid <= 1'b0;
						wlast  <= 1'b0;
						beat   <= beat + 1'b1;
						if (beat_last)
							state <= ST_WB_RESP;
					end
					else if (!wvalid)
					begin
						wvalid <= 1'b1;
						wlast  <= beat_last;
					end
				end
				ST_WB_RESP:
				begin
					if (bvalid)
					begin
						state   <= ST_RF_ADDR;
						arvalid <= 1'b1;
					end
				end
				ST_RF_ADDR:
				begin
					if (arready)
					begin
						arvalid <= 1'b0;
						rready  <= 1'b1;
						beat    <= '0;
						state   <= ST_RF_DATA;
					end
				end
				ST_RF_DATA:
				begin
					if (r_xfer)
					begin
						beat <= beat + 1'b1;
						if (rlast)
						begin
							rready <= 1'b0;
							state  <= ST_IDLE;
						end
					end
				end
				default:
					state <= ST_IDLE;
			endcase
		end
	end

	a_arvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
		arvalid && !arready |=> arvalid);

	// memory must end the burst exactly on beat 16
	a_rlast_beat: assert property (@(posedge clk) disable iff (!rst_n)
		r_xfer |-> (rlast == beat_last));

	a_wlast_beat: assert property (@(posedge clk) disable iff (!rst_n)
		wlast |-> wvalid && beat_last);

endmodule

`default_nettype wire

//--- hw/dcache_data_array.sv
`timescale 1ns/1ns
`default_nettype none

module dcache_data_array
	import dcache_pkg::*;
(
	input  logic    clk,
	input  way_t    rd_way,
	input  index_t  rd_index,
	input  offset_t rd_offset,
	input  logic    wr_en,
	input  way_t    wr_way,
	input  index_t  wr_index,
	input  offset_t wr_offset,
	input  be_t     wr_be,
	input  word_t   wr_data,
	output word_t   rd_data
);
	// both ways in one word array, way bit on top
	word_t                               mem [NUM_WAYS * NUM_SETS * LINE_WORDS];
	logic [WAY_W+INDEX_W+OFFSET_W-1:0]   rd_addr;
	logic [WAY_W+INDEX_W+OFFSET_W-1:0]   wr_addr;

	assign rd_addr = {rd_way, rd_index, rd_offset};
	assign wr_addr = {wr_way, wr_index, wr_offset};

	// byte lanes written under wr_be
	always_ff @(posedge clk)
	begin
		for (int b = 0; b < BE_W; b++)
		begin
			if (wr_en && wr_be[b])
				mem[wr_addr][8*b +: 8] <= wr_data[8*b +: 8];
		end
	end

	// read word valid the cycle after its address
	always_ff @(posedge clk)
	begin
		rd_data <= mem[rd_addr];
	end

endmodule

`default_nettype wire

//--- hw/dcache_tag_lookup.sv
`timescale 1ns/1ns
`default_nettype none

module dcache_tag_lookup
	import dcache_pkg::*;
(
	input  logic   clk,
	input  logic   rst_n,
	input  tag_t   lookup_tag,
	input  index_t lookup_index,
	input  logic   fill_en,
	input  tag_t   fill_tag,
	input  way_t   fill_way,
	input  logic   dirty_set,
	input  logic   dirty_clear,
	input  logic   touch,
	input  way_t   touch_way,
	output logic   hit,
	output way_t   hit_way,
	output way_t   victim_way,
	output tag_t   victim_tag,
	output logic   victim_dirty
);
	tag_t                tag_mem [NUM_WAYS][NUM_SETS];
	logic [NUM_SETS-1:0] valid_q [NUM_WAYS];
	logic [NUM_SETS-1:0] dirty_q [NUM_WAYS];
	// least recently used way of each set
	way_t                lru_q [NUM_SETS];
	logic [NUM_WAYS-1:0] way_valid;
	logic [NUM_WAYS-1:0] way_hit;

	always_comb
	begin
		for (int w = 0; w < NUM_WAYS; w++)
		begin
			way_valid[w] = valid_q[w][lookup_index];
			way_hit[w]   = way_valid[w] && (tag_mem[w][lookup_index] == lookup_tag);
		end
	end

	assign hit     = |way_hit;
	assign hit_way = way_t'(way_hit[1]);

	// an empty way is always taken before the lru one
	always_comb
	begin
		if (!way_valid[0])
			victim_way = way_t'(0);
		else if (!way_valid[1])
			victim_way = way_t'(1);
		else
			victim_way = lru_q[lookup_index];
	end

	assign victim_tag   = tag_mem[victim_way][lookup_index];
	assign victim_dirty = valid_q[victim_way][lookup_index]
		&& dirty_q[victim_way][lookup_index];

	always_ff @(posedge clk)
	begin
		if (fill_en)
			tag_mem[fill_way][lookup_index] <= fill_tag;
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			valid_q <= '{default: '0};
			dirty_q <= '{default: '0};
			lru_q   <= '{default: '0};
		end
		else
		begin
			if (fill_en)
				valid_q[fill_way][lookup_index] <= 1'b1;
			// dirty_set follows the write hit, dirty_clear the written-back victim
			if (dirty_set)
				dirty_q[touch_way][lookup_index] <= 1'b1;
			if (dirty_clear)
				dirty_q[fill_way][lookup_index] <= 1'b0;
			if (touch)
				lru_q[lookup_index] <= ~touch_way;
		end
	end

	// a refill never installs a tag already present in the other way
	a_single_hit: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot0(way_hit));

endmodule

`default_nettype wire

//--- hw/dcache_pkg.sv
`default_nettype none

package dcache_pkg;

	// a cpu byte address holds tag, then index, then word offset, then byte bits
	localparam int ADDR_W     = 32;
	localparam int DATA_W     = 32;
	localparam int BE_W       = DATA_W / 8;
	localparam int BYTE_W     = 2;
	localparam int OFFSET_W   = 4;
	localparam int INDEX_W    = 6;
	localparam int TAG_W      = ADDR_W - INDEX_W - OFFSET_W - BYTE_W;
	localparam int WAY_W      = 1;
	localparam int NUM_WAYS   = 1 << WAY_W;
	localparam int NUM_SETS   = 1 << INDEX_W;
	localparam int LINE_WORDS = 1 << OFFSET_W;

	// every burst is INCR with 16 beats of 4 bytes and all strobes set
	// len, size, burst, id and strobe are therefore not driven as ports

	typedef logic [ADDR_W-1:0]   addr_t;
	typedef logic [DATA_W-1:0]   word_t;
	typedef logic [BE_W-1:0]     be_t;
	typedef logic [TAG_W-1:0]    tag_t;
	typedef logic [INDEX_W-1:0]  index_t;
	typedef logic [OFFSET_W-1:0] offset_t;
	typedef logic [WAY_W-1:0]    way_t;

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_HIT,
		ST_WB_ADDR,
		ST_WB_DATA,
		ST_WB_RESP,
		ST_RF_ADDR,
		ST_RF_DATA
	} ctrl_state_t;

	function automatic tag_t addr_tag(addr_t a);
		return a[BYTE_W+OFFSET_W+INDEX_W +: TAG_W];
	endfunction

	function automatic index_t addr_index(addr_t a);
		return a[BYTE_W+OFFSET_W +: INDEX_W];
	endfunction

	function automatic offset_t addr_offset(addr_t a);
		return a[BYTE_W +: OFFSET_W];
	endfunction

	// burst start address, always at word 0 of the line
	function automatic addr_t line_addr(tag_t tag, index_t index);
		return {tag, index, {(OFFSET_W + BYTE_W){1'b0}}};
	endfunction

endpackage

`default_nettype wire
